// ==== spi_pkg.sv ====
// ************************************************************
// spi slave shared definitions
// byte and address widths, command layout, controller states
// ************************************************************
package spi_pkg;

  localparam int DATA_W     = 8;   // spi byte and register width
  localparam int ADDR_W     = 4;   // register address width
  localparam int NUM_REGS   = 16;  // registers in the bank
  localparam int CMD_WR_BIT = 7;   // 1 = write, 0 = read

  typedef logic [DATA_W-1:0]         data_t;
  typedef logic [ADDR_W-1:0]         addr_t;
  typedef logic [$clog2(DATA_W)-1:0] bit_cnt_t;  // bit index within a byte

  // controller sequencing
  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,  // ss high
    ST_CMD     = 3'd1,  // command byte shifting in
    ST_RD_LOAD = 3'd2,  // one cycle, hand read byte to front end
    ST_RD_DATA = 3'd3,  // read byte shifting out
    ST_WR_DATA = 3'd4   // write byte shifting in
  } ctrl_state_t;

endpackage

// ==== spi_fe.sv ====
// ************************************************************
// spi front end: synchronizes sclk, ss and mosi, detects edges
// and runs the mode 0 receive and transmit shift registers
// ************************************************************
`timescale 1ns/1ps

module spi_fe (
  input  logic           clk,
  input  logic           rst,
  input  logic           sclk,
  input  logic           ss,
  input  logic           mosi,
  input  spi_pkg::data_t tx_byte,
  input  logic           tx_load,
  output logic           miso,
  output spi_pkg::data_t rx_byte,
  output logic           bit_strobe,
  output logic           ss_start,
  output logic           ss_end
);
  import spi_pkg::*;

  logic [1:0] sclk_sync;  // [1] is the synchronized level
  logic [1:0] ss_sync;
  logic [1:0] mosi_sync;
  logic       sclk_q;     // synchronized sclk, one cycle old
  logic       ss_q;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       ss_fall;
  logic       ss_rise;
  logic       selected;   // ss low after sync
  data_t      tx_shift;   // miso comes from the msb
  data_t      tx_hold;    // next byte to send
  logic       tx_pend;    // tx_hold waits for the next sclk fall

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_sync <= 2'b00;  // sclk idles low in mode 0
      ss_sync   <= 2'b11;  // deselected
      mosi_sync <= 2'b00;
      sclk_q    <= 1'b0;
      ss_q      <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      ss_sync   <= {ss_sync[0], ss};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_q    <= sclk_sync[1];
      ss_q      <= ss_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_q;
  assign sclk_fall = ~sclk_sync[1] & sclk_q;
  assign ss_fall   = ~ss_sync[1] & ss_q;
  assign ss_rise   = ss_sync[1] & ~ss_q;
  assign selected  = ~ss_sync[1];

  // registered strobes, 3 clk after the pin change
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_strobe <= 1'b0;
      ss_start   <= 1'b0;
      ss_end     <= 1'b0;
    end else begin
      bit_strobe <= sclk_rise & selected;  // same edge as the rx shift
      ss_start   <= ss_fall;
      ss_end     <= ss_rise;
    end
  end

  // receive, msb first, sampled on sclk rise
  always_ff @(posedge clk) begin
    if (sclk_rise && selected) begin
      rx_byte <= {rx_byte[DATA_W-2:0], mosi_sync[1]};
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load) begin
      tx_hold <= tx_byte;  // rd_data from the register file
    end
  end

  // transmit, master samples on rise so we change on fall
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_shift <= '0;
      tx_pend  <= 1'b0;
    end else if (ss_start || ss_end) begin
      tx_shift <= '0;  // zeros during the command byte
      tx_pend  <= 1'b0;
    end else begin
      if (sclk_fall && selected) begin
        if (tx_pend) begin
          tx_shift <= tx_hold;  // byte boundary, load instead of shift
          tx_pend  <= 1'b0;
        end else begin
          tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
        end
      end
      if (tx_load) begin
        tx_pend <= 1'b1;
      end
    end
  end

  assign miso = tx_shift[DATA_W-1];

endmodule

// ==== spi_bit_counter.sv ====
// ************************************************************
// bit counter: counts sampled bits, flags each complete byte
// ************************************************************
`timescale 1ns/1ps

module spi_bit_counter (
  input  logic clk,
  input  logic rst,
  input  logic ss_start,
  input  logic ss_end,
  input  logic bit_strobe,
  output logic byte_done
);
  import spi_pkg::*;

  bit_cnt_t bit_cnt;  // bits of the current byte seen so far

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
    end else begin
      byte_done <= 1'b0;
      if (ss_start || ss_end) begin
        bit_cnt <= '0;  // partial byte is dropped
      end else if (bit_strobe) begin
        bit_cnt   <= bit_cnt + 1'b1;  // wraps 7 -> 0, bytes back to back
        byte_done <= (bit_cnt == bit_cnt_t'(DATA_W - 1));
      end
    end
  end

endmodule

// ==== spi_ctrl.sv ====
// ************************************************************
// spi controller: decodes the command byte, sequences register
// reads and writes and steps the address after each data byte
// ************************************************************
`timescale 1ns/1ps

module spi_ctrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           ss_start,
  input  logic           ss_end,
  input  logic           byte_done,
  input  spi_pkg::data_t rx_byte,
  output spi_pkg::addr_t reg_addr,
  output logic           reg_we,
  output logic           tx_load
);
  import spi_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  addr_t       addr_nxt;

  always_comb begin
    state_nxt = state;
    addr_nxt  = reg_addr;
    case (state)
      ST_IDLE: begin
        if (ss_start) begin
          state_nxt = ST_CMD;
        end
      end
      ST_CMD: begin
        if (byte_done) begin
          addr_nxt  = rx_byte[ADDR_W-1:0];  // bits 6:4 ignored
          state_nxt = rx_byte[CMD_WR_BIT] ? ST_WR_DATA : ST_RD_LOAD;
        end
      end
      ST_RD_LOAD: begin
        state_nxt = ST_RD_DATA;  // single cycle, tx_load high
      end
      ST_RD_DATA: begin
        if (byte_done) begin
          addr_nxt  = reg_addr + 1'b1;  // wraps 15 -> 0
          state_nxt = ST_RD_LOAD;       // fetch the next byte
        end
      end
      ST_WR_DATA: begin
        if (byte_done) begin
          addr_nxt = reg_addr + 1'b1;  // write lands on the old address
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase

    // deselect ends the transaction from anywhere
    if (ss_end) begin
      state_nxt = ST_IDLE;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= ST_IDLE;
      reg_addr <= '0;
    end else begin
      state    <= state_nxt;
      reg_addr <= addr_nxt;
    end
  end

  assign reg_we  = (state == ST_WR_DATA) && byte_done;  // rx_byte is the wdata
  assign tx_load = (state == ST_RD_LOAD);

endmodule

// ==== spi_regfile.sv ====
// ************************************************************
// register bank: sixteen bytes, one write port and one
// combinational read port
// ************************************************************
`timescale 1ns/1ps

module spi_regfile (
  input  logic           clk,
  input  logic           rst,
  input  logic           we,
  input  spi_pkg::addr_t addr,
  input  spi_pkg::data_t wdata,
  output spi_pkg::data_t rdata
);
  import spi_pkg::*;

  data_t regs [NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;  // bank reads back zero after reset
      end
    end else if (we) begin
      regs[addr] <= wdata;
    end
  end

  // read follows the address in the same cycle
  assign rdata = regs[addr];

endmodule

// ==== spi_slave.sv ====
// ************************************************************
// spi slave register bank top level
// front end, bit counter, controller and register file
// ************************************************************
`timescale 1ns/1ps

module spi_slave (
  input  logic clk,
  input  logic rst,
  input  logic sclk,
  input  logic ss,
  input  logic mosi,
  output logic miso
);
  import spi_pkg::*;

  data_t rx_byte;     // last byte shifted in
  data_t rd_data;     // register at reg_addr
  addr_t reg_addr;
  logic  reg_we;
  logic  tx_load;
  logic  bit_strobe;
  logic  byte_done;
  logic  ss_start;
  logic  ss_end;

  spi_fe spi_fe_inst (
    .clk        (clk),
    .rst        (rst),
    .sclk       (sclk),
    .ss         (ss),
    .mosi       (mosi),
    .tx_byte    (rd_data),
    .tx_load    (tx_load),
    .miso       (miso),
    .rx_byte    (rx_byte),
    .bit_strobe (bit_strobe),
    .ss_start   (ss_start),
    .ss_end     (ss_end)
  );

  spi_bit_counter spi_bit_counter_inst (
    .clk        (clk),
    .rst        (rst),
    .ss_start   (ss_start),
    .ss_end     (ss_end),
    .bit_strobe (bit_strobe),
    .byte_done  (byte_done)
  );

  spi_ctrl spi_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .ss_start  (ss_start),
    .ss_end    (ss_end),
    .byte_done (byte_done),
    .rx_byte   (rx_byte),
    .reg_addr  (reg_addr),
    .reg_we    (reg_we),
    .tx_load   (tx_load)
  );

  spi_regfile spi_regfile_inst (
    .clk   (clk),
    .rst   (rst),
    .we    (reg_we),
    .addr  (reg_addr),
    .wdata (rx_byte),
    .rdata (rd_data)
  );

endmodule

// ==== spi_slave_chk.sv ====
// ************************************************************
// controller checker bound into spi_ctrl
// load timing, byte spacing and transaction start
// ************************************************************
`timescale 1ns/1ps

module spi_slave_chk (
  input logic                 clk,
  input logic                 rst,
  input logic                 ss_start,
  input logic                 byte_done,
  input logic                 reg_we,
  input logic                 tx_load,
  input spi_pkg::ctrl_state_t state
);
  import spi_pkg::*;

  a_load_no_byte: assert property (@(posedge clk) disable iff (rst)
    !(byte_done && tx_load))  // a byte here would skip the address step
    else $error("byte_done in the same cycle as tx_load");

  a_load_after_byte: assert property (@(posedge clk) disable iff (rst)
    tx_load |-> $past(byte_done))  // read fetch follows a full byte
    else $error("tx_load without a completed byte in the cycle before");

  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    ss_start |-> (state == ST_IDLE))  // previous transaction closed by ss_end
    else $error("ss_start while the controller is not idle");

  a_we_single: assert property (@(posedge clk) disable iff (rst)
    reg_we |=> !reg_we)  // one write per byte
    else $error("reg_we high for two cycles in a row");

endmodule

bind spi_ctrl spi_slave_chk spi_slave_chk_inst (
  .clk       (clk),
  .rst       (rst),
  .ss_start  (ss_start),
  .byte_done (byte_done),
  .reg_we    (reg_we),
  .tx_load   (tx_load),
  .state     (state)
);

// ==== tb_spi_slave.sv ====
// ************************************************************
// spi slave testbench: mode 0 master, transaction table
// and a reference register model for the read data
// ************************************************************
`timescale 1ns/1ps

module tb_spi_slave;
  import spi_pkg::*;

  localparam int HALF_SCLK   = 8;   // clk cycles per sclk level
  localparam int MAX_ROWS    = 40;
  localparam int RESET_CYC   = 8;
  // rows x (command + 3 data) bytes x 8 bits x 16 clk, then reset and slack
  localparam int TIMEOUT_CYC = MAX_ROWS * 4 * 8 * 16 + RESET_CYC + 2000;

  logic clk = 1'b0;
  logic rst;
  logic sclk;
  logic ss;
  logic mosi;
  logic miso;

  logic        row_wr    [MAX_ROWS];  // 1 = write
  addr_t       row_addr  [MAX_ROWS];
  int          row_len   [MAX_ROWS];  // data bytes, 1 to 3
  logic [23:0] row_data  [MAX_ROWS];  // byte 0 in bits 7:0
  int          row_abort [MAX_ROWS];  // data bits before ss rises, 0 = full
  int          n_rows    = 0;

  data_t  model [NUM_REGS];  // expected register contents
  integer seed      = 26;
  int     n_checks  = 0;
  int     cycle_cnt = 0;

  spi_slave spi_slave_inst (
    .clk  (clk),
    .rst  (rst),
    .sclk (sclk),
    .ss   (ss),
    .mosi (mosi),
    .miso (miso)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYC) begin
      $display("timeout: test did not finish within %0d clock cycles", TIMEOUT_CYC);
      $display(">>> FAIL");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check_byte(input string name, input data_t got, input data_t exp);
    n_checks++;
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic add_row(input logic wr, input int addr, input int len,
                         input logic [23:0] data, input int abort_bits, input logic rnd);
    logic [31:0] r;
    r = {8'h00, data};
    if (rnd) begin
      r = $random(seed);  // fresh bytes for random rows
    end
    row_wr[n_rows]    = wr;
    row_addr[n_rows]  = addr_t'(addr);
    row_len[n_rows]   = len;
    row_data[n_rows]  = r[23:0];
    row_abort[n_rows] = abort_bits;
    n_rows++;
  endtask

  task automatic build_table();
    for (int i = 0; i < NUM_REGS; i++) begin
      add_row(1'b0, i, 1, 24'h0, 0, 1'b0);  // every register reads 0 after reset
    end
    add_row(1'b1, 5, 1, 24'h0000a5, 0, 1'b0);
    add_row(1'b0, 5, 1, 24'h0, 0, 1'b0);
    add_row(1'b0, 4, 3, 24'h0, 0, 1'b0);       // neighbours of 5
    add_row(1'b1, 14, 3, 24'h5ac33c, 0, 1'b0); // 14, 15 then wrap to 0
    add_row(1'b0, 14, 3, 24'h0, 0, 1'b0);
    add_row(1'b1, 9, 2, 24'h0, 0, 1'b1);
    add_row(1'b1, 1, 3, 24'h0, 0, 1'b1);
    add_row(1'b0, 9, 2, 24'h0, 0, 1'b0);
    add_row(1'b0, 0, 3, 24'h0, 0, 1'b0);
    add_row(1'b1, 15, 1, 24'h0, 0, 1'b1);
    add_row(1'b0, 13, 3, 24'h0, 0, 1'b0);
    add_row(1'b1, 7, 3, 24'h0, 0, 1'b1);
    add_row(1'b0, 7, 3, 24'h0, 0, 1'b0);
    add_row(1'b1, 5, 1, 24'h0000ff, 5, 1'b0);  // cut after 5 data bits
    add_row(1'b0, 5, 1, 24'h0, 0, 1'b0);
    add_row(1'b1, 14, 2, 24'h009966, 13, 1'b0); // first byte lands, second cut
    add_row(1'b0, 14, 3, 24'h0, 0, 1'b0);
  endtask

  // one mode 0 bit: mosi set with sclk low, slave samples on the rise
  task automatic sclk_bit(input logic mo, output logic mi);
    @(posedge clk);
    sclk <= 1'b0;
    mosi <= mo;
    repeat (HALF_SCLK - 1) @(posedge clk);
    @(negedge clk);
    mi = miso;  // settled long before the rise
    @(posedge clk);
    sclk <= 1'b1;
    repeat (HALF_SCLK - 1) @(posedge clk);
  endtask

  task automatic run_row(input int r);
    data_t cmd;
    data_t cmd_miso;
    data_t rx;
    addr_t a;
    logic  mi;
    logic  mo;
    int    nbits;
    int    idx;
    cmd      = {row_wr[r], 3'b000, row_addr[r]};
    cmd_miso = '0;
    rx       = '0;
    nbits    = (row_abort[r] > 0) ? row_abort[r] : row_len[r] * 8;
    @(posedge clk);
    ss <= 1'b0;
    for (int k = DATA_W - 1; k >= 0; k--) begin
      sclk_bit(cmd[k], mi);
      cmd_miso = {cmd_miso[DATA_W-2:0], mi};
    end
    check_byte($sformatf("miso (row %0d command byte)", r), cmd_miso, 8'h00);
    for (int k = 0; k < nbits; k++) begin
      idx = k / 8;
      mo  = row_wr[r] ? row_data[r][idx * 8 + 7 - (k % 8)] : 1'b0;  // msb first
      sclk_bit(mo, mi);
      rx = {rx[DATA_W-2:0], mi};
      if (k % 8 == 7) begin
        a = row_addr[r] + addr_t'(idx);  // wraps mod 16
        if (row_wr[r]) begin
          model[a] = row_data[r][idx * 8 +: 8];
        end else begin
          check_byte($sformatf("miso (row %0d addr %0d)", r, a), rx, model[a]);
        end
      end
    end
    @(posedge clk);
    sclk <= 1'b0;  // back to idle level before deselect
    repeat (HALF_SCLK - 1) @(posedge clk);
    @(posedge clk);
    ss <= 1'b1;
    repeat (HALF_SCLK) @(posedge clk);  // gap between transactions
  endtask

  initial begin
    rst  = 1'b1;
    sclk = 1'b0;
    ss   = 1'b1;
    mosi = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = '0;
    end
    build_table();
    repeat (RESET_CYC) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    if (n_checks > 0) begin
      $display(">>> PASS");
    end else begin
      $display("no checks were run");
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== spi_slave.f ====
spi_pkg.sv
spi_fe.sv
spi_bit_counter.sv
spi_ctrl.sv
spi_regfile.sv
spi_slave.sv
spi_slave_chk.sv
tb_spi_slave.sv
